// File: Makefile
SIM      = verilator
TOP      = tb_atm_header_switch
FILELIST = src.f
VFLAGS   = --binary --timing -j 0 --top-module $(TOP)
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(VFLAGS) -f $(FILELIST)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// File: common/atm_pkg.sv
`default_nettype none

package atm_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int num_ports  = 4;
    // header slots in the fifo, also the starting credit count
    localparam int fifo_depth = 4;

    ////////////////////////////////////////////////////////////////////////////
    // header fields
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [11:0] nni_vpi_t;
    typedef logic [7:0]  uni_vpi_t;
    typedef logic [15:0] vci_t;
    typedef logic [2:0]  pt_t;
    typedef logic [3:0]  gfc_t;
    typedef logic [7:0]  hec_t;

    // one bit per transmit port
    typedef logic [num_ports-1:0] port_mask_t;

    // forwarding table word, mask in 15:12, gfc in 11:8, new vpi in 7:0
    typedef struct packed {
        port_mask_t mask;
        gfc_t       gfc;
        uni_vpi_t   vpi;
    } fwd_entry_t;

    // switched header as held in the fifo, 36 bits
    typedef struct packed {
        port_mask_t mask;
        gfc_t       gfc;
        uni_vpi_t   vpi;
        vci_t       vci;
        logic       clp;
        pt_t        pt;
    } cell_entry_t;

    ////////////////////////////////////////////////////////////////////////////
    // hec over a 32-bit header
    ////////////////////////////////////////////////////////////////////////////

    // crc-8, poly x^8+x^2+x+1, msb first, then xor with the 55h coset
    function automatic hec_t hec_calc(input logic [31:0] hdr);
        hec_t crc;
        logic fb;
        crc = '0;
        for (int i = 31; i >= 0; i--) begin
            fb  = crc[7] ^ hdr[i];
            crc = {crc[6:0], 1'b0};
            if (fb) begin
                crc = crc ^ 8'h07;
            end
        end
        return crc ^ 8'h55;
    endfunction

endpackage

`default_nettype wire

// File: design/atm_header_switch.sv
`default_nettype none

module atm_header_switch import atm_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,

    // nni receive ports
    input  port_mask_t                   rx_req,
    output port_mask_t                   rx_ack,
    input  nni_vpi_t   [num_ports-1:0]   rx_vpi,
    input  vci_t       [num_ports-1:0]   rx_vci,
    input  port_mask_t                   rx_clp,
    input  pt_t        [num_ports-1:0]   rx_pt,
    input  hec_t       [num_ports-1:0]   rx_hec,

    // forwarding table
    output logic                         fwd_rden,
    output uni_vpi_t                     fwd_addr,
    input  fwd_entry_t                   fwd_data,

    // uni transmit ports
    output port_mask_t                   tx_req,
    input  port_mask_t                   tx_ack,
    input  port_mask_t                   tx_full,
    output gfc_t                         tx_gfc,
    output uni_vpi_t                     tx_vpi,
    output vci_t                         tx_vci,
    output logic                         tx_clp,
    output pt_t                          tx_pt,
    output hec_t                         tx_hec
);

    logic        push;
    cell_entry_t push_entry;
    logic        credit_return;
    logic        pop;
    cell_entry_t head;
    logic        not_empty;

    ////////////////////////////////////////////////////////////////////////////
    // ingress, credit link, egress
    ////////////////////////////////////////////////////////////////////////////

    cell_ingress cell_ingress_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .rx_req        (rx_req),
        .rx_ack        (rx_ack),
        .rx_vpi        (rx_vpi),
        .rx_vci        (rx_vci),
        .rx_clp        (rx_clp),
        .rx_pt         (rx_pt),
        .rx_hec        (rx_hec),
        .fwd_rden      (fwd_rden),
        .fwd_addr      (fwd_addr),
        .fwd_data      (fwd_data),
        .push          (push),
        .push_entry    (push_entry),
        .credit_return (credit_return)
    );

    cell_fifo #(
        .depth (fifo_depth)
    ) cell_fifo_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .push          (push),
        .push_entry    (push_entry),
        .pop           (pop),
        .head          (head),
        .not_empty     (not_empty),
        .credit_return (credit_return)
    );

    cell_egress cell_egress_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .head      (head),
        .not_empty (not_empty),
        .pop       (pop),
        .tx_req    (tx_req),
        .tx_ack    (tx_ack),
        .tx_full   (tx_full),
        .tx_gfc    (tx_gfc),
        .tx_vpi    (tx_vpi),
        .tx_vci    (tx_vci),
        .tx_clp    (tx_clp),
        .tx_pt     (tx_pt),
        .tx_hec    (tx_hec)
    );

endmodule

`default_nettype wire

// File: design/cell_fifo.sv
`default_nettype none

module cell_fifo import atm_pkg::*; #(
    parameter int depth = fifo_depth
) (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        push,
    input  cell_entry_t push_entry,

    input  logic        pop,
    output cell_entry_t head,
    output logic        not_empty,
    output logic        credit_return
);

    cell_entry_t                  mem [depth];
    logic [$clog2(depth)-1:0]     wr_ptr;
    logic [$clog2(depth)-1:0]     rd_ptr;
    logic [$clog2(depth+1)-1:0]   count;
    logic                         pop_ok;

    ////////////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////////////

    // writer never pushes without a credit, so no full check
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign pop_ok    = pop && not_empty;

    // each pop frees a slot upstream
    assign credit_return = pop_ok;

    ////////////////////////////////////////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: egress/cell_egress.sv
`default_nettype none

module cell_egress import atm_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    input  cell_entry_t head,
    input  logic        not_empty,
    output logic        pop,

    output port_mask_t  tx_req,
    input  port_mask_t  tx_ack,
    input  port_mask_t  tx_full,
    output gfc_t        tx_gfc,
    output uni_vpi_t    tx_vpi,
    output vci_t        tx_vci,
    output logic        tx_clp,
    output pt_t         tx_pt,
    output hec_t        tx_hec
);

    typedef enum logic [1:0] {st_idle, st_hec, st_send} state_t;

    state_t      state;
    cell_entry_t cur;
    hec_t        uni_hec;
    port_mask_t  done_mask;
    port_mask_t  done_next;
    logic        cell_done;

    assign pop = (state == st_idle) && not_empty;

    ////////////////////////////////////////////////////////////////////////////
    // current cell and uni hec
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (pop) begin
            cur <= head;
        end
    end

    // uni order is gfc, vpi, vci, clp, pt
    always_ff @(posedge clk) begin
        if (state == st_hec) begin
            uni_hec <= hec_calc({cur.gfc, cur.vpi, cur.vci, cur.clp, cur.pt});
        end
    end

    // shared header bus, held until the next pop
    assign tx_gfc = cur.gfc;
    assign tx_vpi = cur.vpi;
    assign tx_vci = cur.vci;
    assign tx_clp = cur.clp;
    assign tx_pt  = cur.pt;
    assign tx_hec = uni_hec;

    ////////////////////////////////////////////////////////////////////////////
    // multicast handshake
    ////////////////////////////////////////////////////////////////////////////

    // unmasked ports count as done from the start
    assign done_next = done_mask | ~cur.mask | (tx_ack & tx_req);
    assign cell_done = (state == st_send) && (&done_next);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            done_mask <= '0;
        end else begin
            case (state)
                st_idle: if (pop) state <= st_hec;
                st_hec:  state <= st_send;
                st_send: if (cell_done) state <= st_idle;
                default: state <= st_idle;
            endcase
            if (cell_done) begin
                done_mask <= '0;
            end else if (state == st_send) begin
                done_mask <= done_next;
            end
        end
    end

    // request waits while the port reports full
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_req <= '0;
        end else begin
            for (int p = 0; p < num_ports; p++) begin
                if (tx_ack[p]) begin
                    tx_req[p] <= 1'b0;
                end else if ((state == st_send) && cur.mask[p] && !done_mask[p]
                             && !tx_full[p]) begin
                    tx_req[p] <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: ingress/cell_ingress.sv
`default_nettype none

module cell_ingress import atm_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,

    input  port_mask_t                   rx_req,
    output port_mask_t                   rx_ack,
    input  nni_vpi_t   [num_ports-1:0]   rx_vpi,
    input  vci_t       [num_ports-1:0]   rx_vci,
    input  port_mask_t                   rx_clp,
    input  pt_t        [num_ports-1:0]   rx_pt,
    input  hec_t       [num_ports-1:0]   rx_hec,

    output logic                         fwd_rden,
    output uni_vpi_t                     fwd_addr,
    input  fwd_entry_t                   fwd_data,

    output logic                         push,
    output cell_entry_t                  push_entry,
    input  logic                         credit_return
);

    typedef enum logic {st_idle, st_check} state_t;
    typedef logic [$clog2(num_ports)-1:0]    port_idx_t;
    typedef logic [$clog2(fifo_depth+1)-1:0] credit_t;

    state_t    state;
    credit_t   credits;
    port_idx_t sel_idx;
    logic      select;
    logic      hec_ok;

    // captured nni header
    nni_vpi_t  cap_vpi;
    vci_t      cap_vci;
    logic      cap_clp;
    pt_t       cap_pt;
    hec_t      cap_hec;

    ////////////////////////////////////////////////////////////////////////////
    // fixed priority select, port 3 wins
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        sel_idx = '0;
        for (int p = 0; p < num_ports; p++) begin
            if (rx_req[p]) begin
                sel_idx = port_idx_t'(p);
            end
        end
    end

    // no credit, no select
    assign select   = (state == st_idle) && (credits != '0) && (|rx_req);
    assign fwd_rden = select;
    assign fwd_addr = rx_vpi[sel_idx][7:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= st_idle;
            rx_ack <= '0;
        end else begin
            rx_ack <= select ? (port_mask_t'(1) << sel_idx) : '0;
            case (state)
                st_idle:  if (select) state <= st_check;
                default:  state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (select) begin
            cap_vpi <= rx_vpi[sel_idx];
            cap_vci <= rx_vci[sel_idx];
            cap_clp <= rx_clp[sel_idx];
            cap_pt  <= rx_pt[sel_idx];
            cap_hec <= rx_hec[sel_idx];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // check cycle, table word arrives here
    ////////////////////////////////////////////////////////////////////////////

    assign hec_ok = hec_calc({cap_vpi, cap_vci, cap_clp, cap_pt}) == cap_hec;

    // bad hec or empty mask just falls back to idle
    assign push = (state == st_check) && hec_ok && (fwd_data.mask != '0);

    assign push_entry.mask = fwd_data.mask;
    assign push_entry.gfc  = fwd_data.gfc;
    assign push_entry.vpi  = fwd_data.vpi;
    assign push_entry.vci  = cap_vci;
    assign push_entry.clp  = cap_clp;
    assign push_entry.pt   = cap_pt;

    // one credit per fifo slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= credit_t'(fifo_depth);
        end else begin
            case ({push, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_atm_header_switch.sv
`default_nettype none

module tb_atm_header_switch import atm_pkg::*; ();

    // 4 unicast, 3 bad hec, 3 zero mask, 6 multicast, 4 priority, 8 back-pressure
    localparam int total_cells = 28;
    localparam port_mask_t mc_masks [6] = '{4'b0011, 4'b1100, 4'b1111,
                                            4'b0101, 4'b1010, 4'b0111};

    typedef struct packed {
        nni_vpi_t vpi;
        vci_t     vci;
        logic     clp;
        pt_t      pt;
        hec_t     hec;
    } nni_hdr_t;

    typedef struct packed {
        logic       valid;
        port_mask_t mask;
        gfc_t       gfc;
        uni_vpi_t   vpi;
        vci_t       vci;
        logic       clp;
        pt_t        pt;
        hec_t       hec;
    } exp_cell_t;

    logic                       clk;
    logic                       rst_n;
    port_mask_t                 rx_req;
    port_mask_t                 rx_ack;
    nni_vpi_t   [num_ports-1:0] rx_vpi;
    vci_t       [num_ports-1:0] rx_vci;
    port_mask_t                 rx_clp;
    pt_t        [num_ports-1:0] rx_pt;
    hec_t       [num_ports-1:0] rx_hec;
    logic                       fwd_rden;
    uni_vpi_t                   fwd_addr;
    fwd_entry_t                 fwd_data;
    port_mask_t                 tx_req;
    port_mask_t                 tx_ack;
    port_mask_t                 tx_full;
    gfc_t                       tx_gfc;
    uni_vpi_t                   tx_vpi;
    vci_t                       tx_vci;
    logic                       tx_clp;
    pt_t                        tx_pt;
    hec_t                       tx_hec;

    integer     seed = 32'h51c3;
    nni_hdr_t   send_q [num_ports][$];
    nni_hdr_t   cur_hdr [num_ports];
    exp_cell_t  exp_q [$];
    int         ack_log [$];
    logic       ack_enable;
    logic       full_mode;
    port_mask_t req_prev;
    port_mask_t full_prev;
    port_mask_t acked_mask;
    int         ack_count;
    int         cells_out;
    int         errors;
    int         checks;
    int         tests_run;
    int         tests_failed;
    int         err_base;
    int         ack_base;
    int         out_base;

    atm_header_switch atm_header_switch_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_req   (rx_req),
        .rx_ack   (rx_ack),
        .rx_vpi   (rx_vpi),
        .rx_vci   (rx_vci),
        .rx_clp   (rx_clp),
        .rx_pt    (rx_pt),
        .rx_hec   (rx_hec),
        .fwd_rden (fwd_rden),
        .fwd_addr (fwd_addr),
        .fwd_data (fwd_data),
        .tx_req   (tx_req),
        .tx_ack   (tx_ack),
        .tx_full  (tx_full),
        .tx_gfc   (tx_gfc),
        .tx_vpi   (tx_vpi),
        .tx_vci   (tx_vci),
        .tx_clp   (tx_clp),
        .tx_pt    (tx_pt),
        .tx_hec   (tx_hec)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // forwarding table model and reference
    ////////////////////////////////////////////////////////////////////////////

    // mask comes from the low nibble, so the vpi picks the destination set
    function automatic fwd_entry_t table_word(input uni_vpi_t addr);
        fwd_entry_t w;
        w.mask = addr[3:0];
        w.gfc  = addr[7:4] ^ 4'h9;
        w.vpi  = addr ^ 8'h5a;
        return w;
    endfunction

    function automatic exp_cell_t expected_cell(input nni_hdr_t h, input fwd_entry_t w);
        exp_cell_t e;
        e.valid = (hec_calc({h.vpi, h.vci, h.clp, h.pt}) == h.hec) && (w.mask != '0);
        e.mask  = w.mask;
        e.gfc   = w.gfc;
        e.vpi   = w.vpi;
        e.vci   = h.vci;
        e.clp   = h.clp;
        e.pt    = h.pt;
        e.hec   = hec_calc({w.gfc, w.vpi, h.vci, h.clp, h.pt});
        return e;
    endfunction

    // registered one-cycle read
    // read enable only in the select cycle, so it lines up with the next rx_ack
    always @(posedge clk) begin
        logic     rd;
        uni_vpi_t addr;
        rd   = fwd_rden;
        addr = fwd_addr;
        #1;
        if (rd) begin
            fwd_data = table_word(addr);
        end
        check_bit("fwd_rden", rd, rx_ack != '0);
    end

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic check_gfc(input string name, input gfc_t got, input gfc_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_vpi(input string name, input uni_vpi_t got, input uni_vpi_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_vci(input string name, input vci_t got, input vci_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_pt(input string name, input pt_t got, input pt_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_hec(input string name, input hec_t got, input hec_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_mask(input string name, input port_mask_t got, input port_mask_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // receive senders, one header at a time per port
    ////////////////////////////////////////////////////////////////////////////

    task automatic queue_cell(input int port, input port_mask_t mask, input logic good);
        nni_hdr_t h;
        int       r;
        r     = $random(seed);
        h.vpi = {r[15:8], mask};
        r     = $random(seed);
        h.vci = r[15:0];
        h.clp = r[16];
        h.pt  = r[19:17];
        h.hec = hec_calc({h.vpi, h.vci, h.clp, h.pt});
        if (!good) begin
            h.hec = h.hec ^ {r[27:21], 1'b1};
        end
        send_q[port].push_back(h);
    endtask

    always @(posedge clk) begin
        port_mask_t ack_seen;
        port_mask_t req_seen;
        exp_cell_t  e;
        ack_seen = rx_ack;
        req_seen = rx_req;
        #1;
        if ($countones(ack_seen) > 1) begin
            report_failure("rx_ack was raised on more than one port at once");
        end
        for (int p = 0; p < num_ports; p++) begin
            if (ack_seen[p]) begin
                if (!req_seen[p]) begin
                    report_failure($sformatf("rx_ack on port %0d without a request", p));
                end else begin
                    ack_count++;
                    ack_log.push_back(p);
                    e = expected_cell(cur_hdr[p], table_word(cur_hdr[p].vpi[7:0]));
                    if (e.valid) begin
                        exp_q.push_back(e);
                    end
                end
                rx_req[p] = 1'b0;
            end else if (!req_seen[p] && send_q[p].size() != 0) begin
                cur_hdr[p] = send_q[p].pop_front();
                rx_vpi[p]  = cur_hdr[p].vpi;
                rx_vci[p]  = cur_hdr[p].vci;
                rx_clp[p]  = cur_hdr[p].clp;
                rx_pt[p]   = cur_hdr[p].pt;
                rx_hec[p]  = cur_hdr[p].hec;
                rx_req[p]  = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // transmit responders and compare
    ////////////////////////////////////////////////////////////////////////////

    // acks after a random wait, full flags toggle randomly when enabled
    always @(posedge clk) begin
        port_mask_t req_s;
        port_mask_t ack_s;
        int         r;
        req_s = tx_req;
        ack_s = tx_ack;
        #1;
        for (int p = 0; p < num_ports; p++) begin
            r = $random(seed);
            if (ack_s[p]) begin
                tx_ack[p] = 1'b0;
            end else if (req_s[p] && ack_enable && r[0]) begin
                tx_ack[p] = 1'b1;
            end
        end
        r       = $random(seed);
        tx_full = full_mode ? port_mask_t'(r) : '0;
    end

    always @(posedge clk) begin
        port_mask_t req_s;
        port_mask_t ack_s;
        exp_cell_t  e;
        req_s = tx_req;
        ack_s = tx_ack;
        if (((req_s & ~req_prev) & full_prev) != '0) begin
            report_failure("tx_req rose on a port that reported full");
        end
        if (req_s != '0 && exp_q.size() == 0) begin
            report_failure("tx_req raised while no cell was expected");
        end else if (exp_q.size() != 0) begin
            e = exp_q[0];
            if (req_s != '0) begin
                check_mask("tx_req outside mask", req_s & ~e.mask, '0);
            end
            for (int p = 0; p < num_ports; p++) begin
                if (req_s[p] && ack_s[p]) begin
                    if (acked_mask[p]) begin
                        report_failure($sformatf("port %0d acked twice for one cell", p));
                    end
                    check_gfc($sformatf("tx_gfc port %0d", p), tx_gfc, e.gfc);
                    check_vpi($sformatf("tx_vpi port %0d", p), tx_vpi, e.vpi);
                    check_vci($sformatf("tx_vci port %0d", p), tx_vci, e.vci);
                    check_bit($sformatf("tx_clp port %0d", p), tx_clp, e.clp);
                    check_pt($sformatf("tx_pt port %0d", p), tx_pt, e.pt);
                    check_hec($sformatf("tx_hec port %0d", p), tx_hec, e.hec);
                    acked_mask[p] = 1'b1;
                end
            end
            // cell done once every masked port has acked
            if ((e.mask & ~acked_mask) == '0) begin
                void'(exp_q.pop_front());
                acked_mask = '0;
                cells_out++;
            end
        end
        req_prev  = req_s;
        full_prev = tx_full;
    end

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic busy();
        logic b;
        b = (rx_req != '0) || (tx_req != '0) || (exp_q.size() != 0);
        for (int p = 0; p < num_ports; p++) begin
            if (send_q[p].size() != 0) begin
                b = 1'b1;
            end
        end
        return b;
    endfunction

    // drain, then a quiet window to catch late transmits
    task automatic wait_idle();
        @(posedge clk);
        while (busy()) begin
            @(posedge clk);
        end
        repeat (16) @(posedge clk);
    endtask

    task automatic start_test();
        err_base = errors;
        ack_base = ack_count;
        out_base = cells_out;
        ack_log.delete();
        @(negedge clk);
    endtask

    task automatic finish_test(input string name, input int exp_acks, input int exp_out);
        if (ack_count - ack_base != exp_acks) begin
            report_failure($sformatf("%s: %0d cells acked on receive, %0d expected",
                                     name, ack_count - ack_base, exp_acks));
        end
        if (cells_out - out_base != exp_out) begin
            report_failure($sformatf("%s: %0d cells transmitted, %0d expected",
                                     name, cells_out - out_base, exp_out));
        end
        tests_run++;
        if (errors == err_base) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d error(s)", name, errors - err_base);
        end
    endtask

    initial begin
        repeat (total_cells * 200) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not finish", total_cells * 200);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        rx_req     = '0;
        rx_vpi     = '0;
        rx_vci     = '0;
        rx_clp     = '0;
        rx_pt      = '0;
        rx_hec     = '0;
        fwd_data   = '0;
        tx_ack     = '0;
        tx_full    = '0;
        ack_enable = 1'b1;
        full_mode  = 1'b0;
        req_prev   = '0;
        full_prev  = '0;
        acked_mask = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        start_test();
        for (int i = 0; i < num_ports; i++) begin
            queue_cell(i, port_mask_t'(1 << i), 1'b1);
        end
        wait_idle();
        finish_test("unicast", 4, 4);

        start_test();
        for (int i = 0; i < 3; i++) begin
            queue_cell(i, port_mask_t'(1 << (3 - i)), 1'b0);
        end
        wait_idle();
        finish_test("bad_hec", 3, 0);

        start_test();
        for (int i = 0; i < 3; i++) begin
            queue_cell(i + 1, '0, 1'b1);
        end
        wait_idle();
        finish_test("zero_mask", 3, 0);

        start_test();
        full_mode = 1'b1;
        for (int i = 0; i < 6; i++) begin
            queue_cell(i % num_ports, mc_masks[i], 1'b1);
        end
        wait_idle();
        full_mode = 1'b0;
        finish_test("multicast", 6, 6);

        // all four raised together, port 3 first
        start_test();
        for (int i = 0; i < num_ports; i++) begin
            queue_cell(i, port_mask_t'(1 << i), 1'b1);
        end
        wait_idle();
        if (ack_log.size() != num_ports) begin
            report_failure("priority: wrong number of receive acks");
        end else begin
            for (int i = 0; i < num_ports; i++) begin
                check_mask("rx_ack order", port_mask_t'(1 << ack_log[i]),
                           port_mask_t'(1 << (num_ports - 1 - i)));
            end
        end
        finish_test("priority", 4, 4);

        // fifo full plus one cell held in egress
        start_test();
        ack_enable = 1'b0;
        for (int i = 0; i < 8; i++) begin
            queue_cell(i % num_ports, port_mask_t'(1 << ((i + 1) % num_ports)), 1'b1);
        end
        while (ack_count - ack_base < fifo_depth + 1) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);
        if (ack_count - ack_base != fifo_depth + 1) begin
            report_failure("back-pressure: switch accepted more cells than it can hold");
        end
        ack_enable = 1'b1;
        wait_idle();
        finish_test("backpressure", 8, 8);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
common/atm_pkg.sv
design/cell_fifo.sv
ingress/cell_ingress.sv
egress/cell_egress.sv
design/atm_header_switch.sv
sim/tb_atm_header_switch.sv
